//--- design/proc_pkg.sv
package proc_pkg;

    ////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////
    localparam int XLEN      = 64;
    localparam int BYTE_W    = 8;
    localparam int INSTR_W   = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_IDX_W = 5;
    localparam int PM_ADDR_W = 6;

    ////////////////////////////////////////
    // Opcodes and function codes
    ////////////////////////////////////////
    localparam logic [6:0] OPC_R_TYPE = 7'b0110011;
    localparam logic [6:0] OPC_I_TYPE = 7'b0010011;
    // Reserved, marks the end of a downloaded program
    localparam logic [6:0] OPC_FINISH = 7'b0001011;

    localparam logic [9:0] F10_ADD  = 10'b0000000000;
    localparam logic [9:0] F10_SUB  = 10'b1000000000;
    localparam logic [9:0] F10_SLL  = 10'b0000000001;
    localparam logic [9:0] F10_SLT  = 10'b0000000010;
    localparam logic [9:0] F10_SLTU = 10'b0000000011;
    localparam logic [9:0] F10_XOR  = 10'b0000000100;
    localparam logic [9:0] F10_SRL  = 10'b0000000101;
    localparam logic [9:0] F10_OR   = 10'b0000000110;
    localparam logic [9:0] F10_AND  = 10'b0000000111;
    localparam logic [9:0] F10_MUL  = 10'b0000001000;

    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_SLLI  = 3'b001;
    localparam logic [2:0] F3_SLTI  = 3'b010;
    localparam logic [2:0] F3_SLTIU = 3'b011;
    localparam logic [2:0] F3_XORI  = 3'b100;
    localparam logic [2:0] F3_SRLI  = 3'b101;
    localparam logic [2:0] F3_ORI   = 3'b110;
    localparam logic [2:0] F3_ANDI  = 3'b111;

    ////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////
    typedef struct packed {
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [9:0]           funct10;
        logic [6:0]           opcode;
    } r_fields_t;

    // Immediate sits where rs2 and the upper funct10 bits are in R-type
    typedef struct packed {
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [4:0]           imm_hi;
        logic [6:0]           imm_lo;
        logic [2:0]           funct3;
        logic [6:0]           opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_view;
        i_fields_t i_view;
    } instr_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_xor,
        alu_or,
        alu_mul
    } alu_op_t;

    typedef struct packed {
        alu_op_t         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } alu_req_t;

    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      data;
    } wb_t;

    typedef struct packed {
        logic [PM_ADDR_W-1:0] addr;
        logic [BYTE_W-1:0]    data;
    } pm_wr_t;

    typedef enum logic [1:0] {
        mode_idle,
        mode_load,
        mode_run
    } proc_mode_t;

endpackage

//--- design/program_loader.sv
`timescale 1ns/100ps

module program_loader #(
    parameter int unsigned FINISH_TIMEOUT = 125000
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rx_flag,
    input  logic [proc_pkg::BYTE_W-1:0] rx_byte,
    input  logic                        pm_idle,
    output logic                        rx_use,
    output proc_pkg::pm_wr_t            pm_wr,
    output logic                        pm_wr_ins,
    output proc_pkg::proc_mode_t        mode,
    output logic                        load_done
);
    import proc_pkg::*;

    localparam int TMR_W = $clog2(FINISH_TIMEOUT + 1);

    typedef enum logic [1:0] {
        ld_wait_byte,
        ld_pop,
        ld_write
    } ld_state_t;

    proc_mode_t           mode_q;
    ld_state_t            ld_state;
    logic [1:0]           byte_pos;
    logic                 finish_q;
    logic [PM_ADDR_W-1:0] addr_q;
    logic [BYTE_W-1:0]    data_q;
    logic [TMR_W-1:0]     empty_cnt;
    logic                 finish_hit;
    logic                 timeout_hit;

    // Opcode byte of a word is the first of every four
    assign finish_hit  = (byte_pos == 2'd0) && (rx_byte[6:0] == OPC_FINISH);
    assign timeout_hit = !rx_flag && (empty_cnt == TMR_W'(FINISH_TIMEOUT - 1));

    assign rx_use    = (ld_state == ld_pop);
    assign pm_wr_ins = (ld_state == ld_write) && pm_idle;
    assign pm_wr.addr = addr_q;
    assign pm_wr.data = data_q;
    assign mode      = mode_q;

    ////////////////////////////////////////
    // Empty FIFO timer
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            empty_cnt <= '0;
        end else if (mode_q == mode_load && ld_state == ld_wait_byte && !rx_flag) begin
            empty_cnt <= empty_cnt + 1'b1;
        end else begin
            empty_cnt <= '0;
        end
    end

    ////////////////////////////////////////
    // Mode and load FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q    <= mode_idle;
            ld_state  <= ld_wait_byte;
            byte_pos  <= 2'd0;
            finish_q  <= 1'b0;
            addr_q    <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            case (mode_q)
                mode_idle: begin
                    if (rx_flag) begin
                        mode_q <= mode_load;
                    end
                end
                mode_load: begin
                    case (ld_state)
                        ld_wait_byte: begin
                            if (rx_flag) begin
                                finish_q <= finish_hit;
                                ld_state <= ld_pop;
                            end else if (timeout_hit) begin
                                mode_q    <= mode_run;
                                load_done <= 1'b1;
                            end
                        end
                        ld_pop: begin
                            byte_pos <= byte_pos + 2'd1;
                            // Finish byte leaves the FIFO but never reaches memory
                            if (finish_q) begin
                                mode_q    <= mode_run;
                                load_done <= 1'b1;
                                ld_state  <= ld_wait_byte;
                            end else begin
                                ld_state <= ld_write;
                            end
                        end
                        ld_write: begin
                            if (pm_idle) begin
                                addr_q   <= addr_q + 1'b1;
                                ld_state <= ld_wait_byte;
                            end
                        end
                        default: ld_state <= ld_wait_byte;
                    endcase
                end
                default: begin
                    // Run mode is kept until reset
                end
            endcase
        end
    end

    // Head byte, taken as it is popped
    always_ff @(posedge clk) begin
        if (mode_q == mode_load && ld_state == ld_wait_byte && rx_flag) begin
            data_q <= rx_byte;
        end
    end

    // Write held off by a busy memory keeps address and data, no pop meanwhile
    a_hold_while_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        (ld_state == ld_write && !pm_idle) |=> !rx_use && $stable(pm_wr));

    // Popped byte is the one held for the write
    a_pop_matches_data : assert property (
        @(posedge clk) disable iff (!rst_n) rx_use |-> (pm_wr.data == rx_byte));

endmodule

//--- design/exec_control.sv
`timescale 1ns/100ps

module exec_control (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load_done,
    input  logic                           boot,
    input  proc_pkg::instr_u               instr,
    input  logic                           legal,
    output proc_pkg::instr_u               instr_q,
    output logic                           idle,
    output logic                           wb_en,
    output logic [proc_pkg::REG_IDX_W-1:0] wb_rd
);

    typedef enum logic [1:0] {
        st_ready,
        st_exec,
        st_wb
    } run_state_t;

    run_state_t state;
    logic       armed;
    logic       accept;

    // Boots before the program is loaded, or while busy, are dropped
    assign accept = armed && (state == st_ready) && boot;
    assign idle   = (state == st_ready);
    assign wb_rd  = instr_q.r_view.rd;

    ////////////////////////////////////////
    // Run sequencer
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_ready;
            armed <= 1'b0;
            wb_en <= 1'b0;
        end else begin
            if (load_done) begin
                armed <= 1'b1;
            end
            case (state)
                st_ready: begin
                    if (accept) begin
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    // ALU result lands on this edge, write it on the next
                    state <= st_wb;
                    wb_en <= legal;
                end
                st_wb: begin
                    state <= st_ready;
                    wb_en <= 1'b0;
                end
                default: state <= st_ready;
            endcase
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
        end
    end

    a_wb_single_cycle : assert property (
        @(posedge clk) disable iff (!rst_n) wb_en |=> !wb_en);

endmodule

//--- design/instr_decode.sv
`timescale 1ns/100ps

module instr_decode (
    input  proc_pkg::instr_u               instr_q,
    input  logic [proc_pkg::XLEN-1:0]      rs1_data,
    input  logic [proc_pkg::XLEN-1:0]      rs2_data,
    output logic [proc_pkg::REG_IDX_W-1:0] rs1_idx,
    output logic [proc_pkg::REG_IDX_W-1:0] rs2_idx,
    output proc_pkg::alu_req_t             req,
    output logic                           legal
);
    import proc_pkg::*;

    r_fields_t       r_f;
    i_fields_t       i_f;
    logic [XLEN-1:0] imm_ext;

    assign r_f = instr_q.r_view;
    assign i_f = instr_q.i_view;

    // rd and rs1 share positions in both views
    assign rs1_idx = r_f.rs1;
    assign rs2_idx = r_f.rs2;
    assign imm_ext = {{(XLEN - 12){1'b0}}, i_f.imm_hi, i_f.imm_lo};

    always_comb begin
        req.op = alu_add;
        req.a  = rs1_data;
        req.b  = rs2_data;
        legal  = 1'b0;
        case (r_f.opcode)
            OPC_R_TYPE: begin
                legal = 1'b1;
                case (r_f.funct10)
                    F10_ADD:  req.op = alu_add;
                    F10_SUB:  req.op = alu_sub;
                    F10_SLL:  req.op = alu_sll;
                    F10_SRL:  req.op = alu_srl;
                    F10_SLT:  req.op = alu_slt;
                    F10_SLTU: req.op = alu_sltu;
                    F10_AND:  req.op = alu_and;
                    F10_XOR:  req.op = alu_xor;
                    F10_OR:   req.op = alu_or;
                    F10_MUL:  req.op = alu_mul;
                    default:  legal  = 1'b0;
                endcase
            end
            OPC_I_TYPE: begin
                // Every funct3 value has an I-type form
                legal = 1'b1;
                req.b = imm_ext;
                case (i_f.funct3)
                    F3_ADDI:  req.op = alu_add;
                    F3_SLLI:  req.op = alu_sll;
                    F3_SRLI:  req.op = alu_srl;
                    F3_SLTI:  req.op = alu_slt;
                    F3_SLTIU: req.op = alu_sltu;
                    F3_XORI:  req.op = alu_xor;
                    F3_ORI:   req.op = alu_or;
                    F3_ANDI:  req.op = alu_and;
                endcase
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

endmodule

//--- design/alu.sv
`timescale 1ns/100ps

module alu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  proc_pkg::alu_req_t        req,
    output logic [proc_pkg::XLEN-1:0] result
);
    import proc_pkg::*;

    logic [XLEN-1:0] calc;
    logic [5:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    // Shift amount uses only the low 6 bits of b
    assign shamt       = req.b[5:0];
    assign lt_signed   = $signed(req.a) < $signed(req.b);
    assign lt_unsigned = req.a < req.b;

    ////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////
    always_comb begin
        case (req.op)
            alu_add:  calc = req.a + req.b;
            alu_sub:  calc = req.a - req.b;
            alu_sll:  calc = req.a << shamt;
            alu_srl:  calc = req.a >> shamt;
            alu_slt:  calc = {{(XLEN - 1){1'b0}}, lt_signed};
            alu_sltu: calc = {{(XLEN - 1){1'b0}}, lt_unsigned};
            alu_and:  calc = req.a & req.b;
            alu_xor:  calc = req.a ^ req.b;
            alu_or:   calc = req.a | req.b;
            // Low half of the product only
            alu_mul:  calc = req.a * req.b;
            default:  calc = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= calc;
        end
    end

endmodule

//--- design/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [proc_pkg::REG_IDX_W-1:0] rs1_idx,
    input  logic [proc_pkg::REG_IDX_W-1:0] rs2_idx,
    input  logic                           wb_en,
    input  logic [proc_pkg::REG_IDX_W-1:0] wb_rd,
    input  logic [proc_pkg::XLEN-1:0]      result,
    output logic [proc_pkg::XLEN-1:0]      rs1_data,
    output logic [proc_pkg::XLEN-1:0]      rs2_data,
    output proc_pkg::wb_t                  wb
);
    import proc_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];
    wb_t             wb_q;

    // Asynchronous read ports
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];
    assign wb       = wb_q;

    // x0 is an ordinary register here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            wb_q <= '0;
        end else begin
            wb_q.valid <= wb_en;
            if (wb_en) begin
                regs[wb_rd] <= result;
                wb_q.rd     <= wb_rd;
                wb_q.data   <= result;
            end
        end
    end

endmodule

//--- design/processor_top.sv
`timescale 1ns/100ps

module processor_top #(
    parameter int unsigned FINISH_TIMEOUT = 125000
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rx_flag,
    input  logic [proc_pkg::BYTE_W-1:0] rx_byte,
    input  logic                        pm_idle,
    input  logic                        boot,
    input  proc_pkg::instr_u            instr,
    output logic                        rx_use,
    output proc_pkg::pm_wr_t            pm_wr,
    output logic                        pm_wr_ins,
    output proc_pkg::proc_mode_t        mode,
    output logic                        idle,
    output proc_pkg::wb_t               wb
);
    import proc_pkg::*;

    logic                 load_done;
    instr_u               instr_q;
    logic                 legal;
    logic                 wb_en;
    logic [REG_IDX_W-1:0] wb_rd;
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    alu_req_t             req;
    logic [XLEN-1:0]      result;

    ////////////////////////////////////////
    // Program download
    ////////////////////////////////////////
    program_loader #(
        .FINISH_TIMEOUT(FINISH_TIMEOUT)
    ) u_loader (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_flag  (rx_flag),
        .rx_byte  (rx_byte),
        .pm_idle  (pm_idle),
        .rx_use   (rx_use),
        .pm_wr    (pm_wr),
        .pm_wr_ins(pm_wr_ins),
        .mode     (mode),
        .load_done(load_done)
    );

    ////////////////////////////////////////
    // Execute path
    ////////////////////////////////////////
    exec_control u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_done(load_done),
        .boot     (boot),
        .instr    (instr),
        .legal    (legal),
        .instr_q  (instr_q),
        .idle     (idle),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd)
    );

    instr_decode u_decode (
        .instr_q (instr_q),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .req     (req),
        .legal   (legal)
    );

    alu u_alu (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .result(result)
    );

    register_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .result  (result),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb      (wb)
    );

endmodule

//--- sim/tb_processor.sv
`timescale 1ns/100ps

module tb_processor;
    import proc_pkg::*;

    localparam int unsigned FINISH_TIMEOUT = 20;

    logic              clk;
    logic              rst_n;
    logic              rx_flag;
    logic [BYTE_W-1:0] rx_byte;
    logic              pm_idle;
    logic              boot;
    instr_u            instr;
    logic              rx_use;
    pm_wr_t            pm_wr;
    logic              pm_wr_ins;
    proc_mode_t        mode;
    logic              idle;
    wb_t               wb;

    logic [7:0]  fifo_q[$];
    logic [7:0]  exp_bytes[$];
    logic [31:0] case_instr[$];
    logic        case_legal[$];
    logic [4:0]  case_rd[$];
    logic [63:0] case_val[$];
    logic [63:0] ref_regs[REG_COUNT];
    int          wr_idx;
    logic        pop_pending;

    processor_top #(
        .FINISH_TIMEOUT(FINISH_TIMEOUT)
    ) dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_flag  (rx_flag),
        .rx_byte  (rx_byte),
        .pm_idle  (pm_idle),
        .boot     (boot),
        .instr    (instr),
        .rx_use   (rx_use),
        .pm_wr    (pm_wr),
        .pm_wr_ins(pm_wr_ins),
        .mode     (mode),
        .idle     (idle),
        .wb       (wb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    ////////////////////////////////////////
    // FIFO and program memory models
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (rst_n && rx_use) begin
            if (fifo_q.size() == 0) begin
                $display("Byte popped from an empty receive FIFO at %0t ns", $time);
                stop_on_error();
            end
            pop_pending = 1'b1;
        end
        if (rst_n && pm_wr_ins) begin
            if (wr_idx >= exp_bytes.size()) begin
                $display("Unexpected program memory write at %0t ns", $time);
                stop_on_error();
            end
            check("pm_wr.addr", 64'(pm_wr.addr), 64'(wr_idx));
            check("pm_wr.data", 64'(pm_wr.data), 64'(exp_bytes[wr_idx]));
            wr_idx++;
        end
    end

    always @(negedge clk) begin
        if (pop_pending) begin
            void'(fifo_q.pop_front());
            pop_pending = 1'b0;
        end
        rx_flag = (fifo_q.size() > 0);
        rx_byte = (fifo_q.size() > 0) ? fifo_q[0] : 8'h00;
        // Memory busy now and then while loading
        pm_idle = (mode == mode_load) ? (($urandom % 4) != 0) : 1'b1;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic logic [63:0] model_result(input logic [31:0] w);
        logic [63:0] a;
        logic [63:0] b;
        logic [3:0]  sel;
        a = ref_regs[w[26:22]];
        if (w[6:0] == OPC_I_TYPE) begin
            b = {52'd0, w[21:10]};
            case (w[9:7])
                3'd0: sel = 4'd0;
                3'd1: sel = 4'd2;
                3'd2: sel = 4'd4;
                3'd3: sel = 4'd5;
                3'd4: sel = 4'd7;
                3'd5: sel = 4'd3;
                3'd6: sel = 4'd8;
                default: sel = 4'd6;
            endcase
        end else begin
            b = ref_regs[w[21:17]];
            case (w[16:7])
                10'h000: sel = 4'd0;
                10'h200: sel = 4'd1;
                10'h001: sel = 4'd2;
                10'h005: sel = 4'd3;
                10'h002: sel = 4'd4;
                10'h003: sel = 4'd5;
                10'h007: sel = 4'd6;
                10'h004: sel = 4'd7;
                10'h006: sel = 4'd8;
                default: sel = 4'd9;
            endcase
        end
        case (sel)
            4'd0: return a + b;
            4'd1: return a - b;
            4'd2: return a << b[5:0];
            4'd3: return a >> b[5:0];
            4'd4: return {63'd0, $signed(a) < $signed(b)};
            4'd5: return {63'd0, a < b};
            4'd6: return a & b;
            4'd7: return a ^ b;
            4'd8: return a | b;
            default: return a * b;
        endcase
    endfunction

    task automatic read_cases();
        int          fd;
        int          code;
        logic [7:0]  tag;
        logic [31:0] w;
        logic [63:0] v;
        logic [4:0]  rd;
        string       line;
        fd = $fopen("sim/processor_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open sim/processor_cases.txt");
            stop_on_error();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                code = $fgets(line, fd);
            end else if (tag == "P") begin
                code = $fscanf(fd, "%h", w);
                exp_bytes.push_back(w[7:0]);
            end else if (tag == "I") begin
                code = $fscanf(fd, "%h %d %h", w, rd, v);
                case_instr.push_back(w);
                case_legal.push_back(1'b1);
                case_rd.push_back(rd);
                case_val.push_back(v);
            end else begin
                code = $fscanf(fd, "%h", w);
                case_instr.push_back(w);
                case_legal.push_back(1'b0);
                case_rd.push_back(5'd0);
                case_val.push_back(64'd0);
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        fifo_q.delete();
        pop_pending = 1'b0;
        wr_idx = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic wait_run_mode(input int limit);
        int n;
        for (n = 0; n < limit && mode != mode_run; n++) begin
            @(negedge clk);
        end
        if (mode != mode_run) begin
            $display("Timed out waiting for run mode");
            stop_on_error();
        end
    endtask

    task automatic run_instr(input int k);
        int          n;
        logic [63:0] exp;
        for (n = 0; n < 20 && !idle; n++) begin
            @(negedge clk);
        end
        if (!idle) begin
            $display("Timed out waiting for idle before boot");
            stop_on_error();
        end
        instr = case_instr[k];
        boot  = 1'b1;
        @(posedge clk);
        for (n = 1; n <= 8; n++) begin
            @(negedge clk);
            boot = 1'b0;
            if (wb.valid) begin
                break;
            end
        end
        if (!case_legal[k]) begin
            check("wb.valid on illegal instruction", 64'(n <= 5), 64'd0);
            check("idle after illegal instruction", 64'(idle), 64'd1);
        end else begin
            if (n > 8) begin
                $display("Timed out waiting for write-back of case %0d", k);
                stop_on_error();
            end
            exp = model_result(case_instr[k]);
            check("model against file value", exp, case_val[k]);
            check("write-back cycle", 64'(n), 64'd3);
            check("wb.rd", 64'(wb.rd), 64'(case_rd[k]));
            check("wb.data", wb.data, exp);
            ref_regs[case_rd[k]] = exp;
            @(negedge clk);
            check("wb.valid width", 64'(wb.valid), 64'd0);
        end
    endtask

    initial begin
        void'($urandom(8975));
        rst_n   = 1'b0;
        rx_flag = 1'b0;
        rx_byte = '0;
        pm_idle = 1'b1;
        boot    = 1'b0;
        instr   = '0;
        pop_pending = 1'b0;
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        read_cases();

        // Load a program ending on a finish byte
        apply_reset();
        check("mode after reset", 64'(mode), 64'(mode_idle));
        check("idle after reset", 64'(idle), 64'd1);
        check("rx_use after reset", 64'(rx_use), 64'd0);
        check("pm_wr_ins after reset", 64'(pm_wr_ins), 64'd0);
        check("wb.valid after reset", 64'(wb.valid), 64'd0);
        foreach (exp_bytes[i]) begin
            fifo_q.push_back(exp_bytes[i]);
        end
        fifo_q.push_back(8'h0B);
        wait_run_mode(2000);
        repeat (2) @(negedge clk);
        check("bytes written", 64'(wr_idx), 64'(exp_bytes.size()));
        check("FIFO left over", 64'(fifo_q.size()), 64'd0);

        foreach (case_instr[k]) begin
            run_instr(k);
        end

        // Single byte then an empty FIFO
        apply_reset();
        exp_bytes.delete();
        exp_bytes.push_back(8'h5A);
        fifo_q.push_back(8'h5A);
        wait_run_mode(FINISH_TIMEOUT + 20);
        check("bytes written before timeout", 64'(wr_idx), 64'd1);

        $display("Test passed");
        $finish;
    end

endmodule

//--- sim/processor_cases.txt
# P <byte>: program byte, I <instr> <rd> <value>: instruction and result
# X <instr>: illegal instruction, no write-back
P 13
P 00
P 00
P 00
P 33
P 01
P 02
P 03
I 081FFC13 1 00000000000007FF
I 103FFC13 2 0000000000000FFF
I 1840A093 3 0007FF0000000000
I 20050033 4 FFFFFFFFFFFFF001
I 28C80033 5 0007FEFFFFFFF001
I 31020133 6 0000000000000001
I 390201B3 7 0000000000000000
I 41440433 8 7FE800FFFF001FFF
I 48CC02B3 9 0003FF8000000000
I 517C3E13 10 0007FEFFFFFFFF0E
I 5A03C393 11 00000000000000F0
I 62960333 12 0007FEFFFFFFFFFE
I 68600193 13 0000000000000001
I 705A00B3 14 0000000000000FFE
I 78048F13 15 0000000000000123
I 83C403B3 16 0000000000000123
I 89001513 17 0000000000000001
X 9001FFB3
I 90C01293 18 00007FF000000000
I 98440233 19 0000000000000800
X A0000003

//--- vlog.f
design/proc_pkg.sv
design/program_loader.sv
design/exec_control.sv
design/instr_decode.sv
design/alu.sv
design/register_file.sv
design/processor_top.sv
sim/tb_processor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_processor \
    -o sim_tb_processor > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Compilation failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb_processor > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
